/* sources.f */
design/io_bus_pkg.sv
design/synchronizer.sv
design/gpio_controller.sv
design/gpio_edge_irq.sv
design/io_read_mux.sv
design/gpio_subsystem.sv
testbench/gpio_subsystem_tb.sv

/* Makefile */
# Verilator build and run of the GPIO subsystem testbench

LOG = sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench and check the log"
	@echo "  clean  remove the build folder and the log"
	@echo "  help   show this list"

test:
	verilator --binary --timing --top-module gpio_subsystem_tb -Mdir obj_dir -f sources.f
	./obj_dir/Vgpio_subsystem_tb | tee $(LOG)
	grep -q "Result: PASSED" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

/* testbench/gpio_subsystem_tb.sv */
/*
 * Testbench for the GPIO subsystem with clock, reset, bus tasks,
 * pin drivers with pull-downs, directed tests and a watchdog
 */

`timescale 1ns/100ps

module gpio_subsystem_tb
    import io_bus_pkg::*;
;

    localparam int PINS = 8;
    localparam logic [31:0] GPIO_BASE = 32'h100;
    localparam logic [31:0] IRQ_BASE = 32'h110;
    localparam logic [31:0] DIR_ADDR = GPIO_BASE + OFFSET_DIRECTION;
    localparam logic [31:0] VALUE_ADDR = GPIO_BASE + OFFSET_VALUE;
    localparam logic [31:0] MASK_ADDR = IRQ_BASE + OFFSET_IRQ_MASK;
    localparam logic [31:0] STATUS_ADDR = IRQ_BASE + OFFSET_IRQ_STATUS;
    // Inside the GPIO window but past its two registers
    localparam logic [31:0] UNMAPPED_ADDR = GPIO_BASE + 32'h8;
    localparam logic [31:0] SEED = 32'd14071;
    localparam int HALF_PERIOD_NS = 4;
    // The tests need about 125 clock cycles, close to 1000 ns of simulated time
    localparam int WATCHDOG_NS = 20000;

    logic clk;
    logic reset;
    io_bus_req_t bus_req;
    logic [31:0] read_data;
    logic irq;
    wire [PINS-1:0] gpio_pins;

    // Per-pin testbench drivers that stay at z unless enabled
    logic [PINS-1:0] pin_drive;
    logic [PINS-1:0] pin_enable;

    int error_count;
    logic [31:0] rng_state;

    gpio_subsystem gpio_subsystem_i (
        .clk(clk),
        .reset(reset),
        .bus_req(bus_req),
        .read_data(read_data),
        .irq(irq),
        .gpio_pins(gpio_pins)
    );

    // The pull-down is weaker than both the DUT and the testbench drivers
    genvar pin_idx;
    generate
        for (pin_idx = 0; pin_idx < PINS; pin_idx++)
        begin : pin_gen
            assign gpio_pins[pin_idx] = pin_enable[pin_idx] ? pin_drive[pin_idx] : 1'bz;
            pulldown pin_pulldown (gpio_pins[pin_idx]);
        end
    endgenerate

    always #HALF_PERIOD_NS clk = ~clk;

    // 32-bit xorshift step
    function automatic logic [31:0] xorshift32(input logic [31:0] state);
        logic [31:0] x;
        x = state;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic report_mismatch(input string name, input logic [31:0] expected,
                                   input logic [31:0] actual);
        $display("mismatch at %0d ns: %s expected 0x%h, actual 0x%h",
                 $time, name, expected, actual);
        error_count++;
    endtask

    task automatic wait_cycles(input int count);
        repeat (count) @(negedge clk);
    endtask

    // One-cycle write strobe that the register takes on the rising edge in between
    task automatic bus_write(input logic [31:0] address, input logic [31:0] data);
        @(negedge clk);
        bus_req.write_en = 1'b1;
        bus_req.address = address;
        bus_req.write_data = data;
        @(negedge clk);
        bus_req.write_en = 1'b0;
        bus_req.address = '0;
        bus_req.write_data = '0;
    endtask

    // One-cycle read pulse whose data is stable at the following falling edge
    task automatic bus_read(input logic [31:0] address, output logic [31:0] data);
        @(negedge clk);
        bus_req.read_en = 1'b1;
        bus_req.address = address;
        @(negedge clk);
        bus_req.read_en = 1'b0;
        bus_req.address = '0;
        data = read_data;
    endtask

    task automatic reset_state_test();
        logic [31:0] data;
        bus_read(DIR_ADDR, data);
        if (data !== 32'h0)
            report_mismatch("direction", 32'h0, data);
        bus_read(MASK_ADDR, data);
        if (data !== 32'h0)
            report_mismatch("irq_mask", 32'h0, data);
        bus_read(STATUS_ADDR, data);
        if (data !== 32'h0)
            report_mismatch("irq_status", 32'h0, data);
        if (irq !== 1'b0)
            report_mismatch("irq", 32'h0, 32'(irq));
        if (gpio_pins !== '0)
            report_mismatch("gpio_pins", 32'h0, 32'(gpio_pins));
    endtask

    task automatic output_drive_test();
        logic [PINS-1:0] value;
        logic [31:0] data;
        rng_state = xorshift32(rng_state);
        value = rng_state[PINS-1:0];
        bus_write(DIR_ADDR, 32'hff);
        bus_write(VALUE_ADDR, 32'(value));
        // The drivers follow the register one edge after the write
        if (gpio_pins !== value)
            report_mismatch("gpio_pins", 32'(value), 32'(gpio_pins));
        wait_cycles(3);
        bus_read(VALUE_ADDR, data);
        if (data !== 32'(value))
            report_mismatch("value", 32'(value), data);
    endtask

    task automatic mixed_input_test();
        logic [PINS-1:0] dir;
        logic [PINS-1:0] out_value;
        logic [PINS-1:0] in_value;
        logic [PINS-1:0] expected;
        logic [31:0] data;
        for (int pattern = 0; pattern < 4; pattern++)
        begin
            rng_state = xorshift32(rng_state);
            dir = rng_state[PINS-1:0];
            rng_state = xorshift32(rng_state);
            out_value = rng_state[PINS-1:0];
            rng_state = xorshift32(rng_state);
            in_value = rng_state[PINS-1:0];
            // Release our drivers before the DUT takes over any pin
            @(negedge clk);
            pin_enable = '0;
            bus_write(DIR_ADDR, 32'(dir));
            bus_write(VALUE_ADDR, 32'(out_value));
            @(negedge clk);
            pin_drive = in_value;
            pin_enable = ~dir;
            wait_cycles(4);
            bus_read(VALUE_ADDR, data);
            expected = (dir & out_value) | (~dir & in_value);
            if (data !== 32'(expected))
                report_mismatch("value", 32'(expected), data);
        end
        @(negedge clk);
        pin_enable = '0;
        bus_write(DIR_ADDR, 32'h0);
    endtask

    task automatic edge_irq_test();
        int masked_pin;
        int unmasked_pin;
        logic [PINS-1:0] masked_bit;
        logic [PINS-1:0] unmasked_bit;
        logic [PINS-1:0] mask;
        logic [31:0] data;
        rng_state = xorshift32(rng_state);
        masked_pin = int'(rng_state % 32'(PINS));
        rng_state = xorshift32(rng_state);
        unmasked_pin = (masked_pin + 1 + int'(rng_state % 32'(PINS - 1))) % PINS;
        masked_bit = PINS'(1) << masked_pin;
        unmasked_bit = PINS'(1) << unmasked_pin;
        rng_state = xorshift32(rng_state);
        mask = (rng_state[PINS-1:0] | masked_bit) & ~unmasked_bit;

        // Hold all pins low and drop the flags left over from earlier tests
        @(negedge clk);
        pin_drive = '0;
        pin_enable = '1;
        wait_cycles(4);
        bus_write(STATUS_ADDR, 32'hff);
        bus_read(STATUS_ADDR, data);
        if (data !== 32'h0)
            report_mismatch("irq_status", 32'h0, data);
        bus_write(MASK_ADDR, 32'(mask));
        if (irq !== 1'b0)
            report_mismatch("irq", 32'h0, 32'(irq));

        @(negedge clk);
        pin_drive = masked_bit | unmasked_bit;
        // Two synchronizer edges and one more for the status flag
        wait_cycles(4);
        if (irq !== 1'b1)
            report_mismatch("irq", 32'h1, 32'(irq));
        bus_read(STATUS_ADDR, data);
        if (data !== 32'(masked_bit | unmasked_bit))
            report_mismatch("irq_status", 32'(masked_bit | unmasked_bit), data);

        // Clearing the masked flag drops irq while the other flag stays
        bus_write(STATUS_ADDR, 32'(masked_bit));
        if (irq !== 1'b0)
            report_mismatch("irq", 32'h0, 32'(irq));
        bus_read(STATUS_ADDR, data);
        if (data !== 32'(unmasked_bit))
            report_mismatch("irq_status", 32'(unmasked_bit), data);

        // Falling edges leave the status alone
        @(negedge clk);
        pin_drive = '0;
        wait_cycles(4);
        bus_read(STATUS_ADDR, data);
        if (data !== 32'(unmasked_bit))
            report_mismatch("irq_status", 32'(unmasked_bit), data);
        if (irq !== 1'b0)
            report_mismatch("irq", 32'h0, 32'(irq));

        bus_write(STATUS_ADDR, 32'hff);
        @(negedge clk);
        pin_enable = '0;
    endtask

    task automatic read_mux_test();
        logic [PINS-1:0] dir;
        logic [PINS-1:0] mask;
        rng_state = xorshift32(rng_state);
        dir = rng_state[PINS-1:0];
        rng_state = xorshift32(rng_state);
        mask = rng_state[PINS-1:0];
        bus_write(DIR_ADDR, 32'(dir));
        bus_write(MASK_ADDR, 32'(mask));

        // Three reads with no gap between them are each answered one cycle after their pulse
        @(negedge clk);
        bus_req.read_en = 1'b1;
        bus_req.address = DIR_ADDR;
        @(negedge clk);
        if (read_data !== 32'(dir))
            report_mismatch("read_data", 32'(dir), read_data);
        bus_req.address = UNMAPPED_ADDR;
        @(negedge clk);
        if (read_data !== 32'h0)
            report_mismatch("read_data", 32'h0, read_data);
        bus_req.address = MASK_ADDR;
        @(negedge clk);
        bus_req.read_en = 1'b0;
        bus_req.address = '0;
        if (read_data !== 32'(mask))
            report_mismatch("read_data", 32'(mask), read_data);

        // No read pending, so the last word stays on the bus
        wait_cycles(3);
        if (read_data !== 32'(mask))
            report_mismatch("read_data", 32'(mask), read_data);
    endtask

    initial
    begin
        #WATCHDOG_NS;
        $display("Watchdog expired after %0d ns before the tests finished", WATCHDOG_NS);
        $display("Result: FAILED");
        $finish;
    end

    initial
    begin
        clk = 1'b0;
        reset = 1'b1;
        bus_req = '0;
        pin_drive = '0;
        pin_enable = '0;
        error_count = 0;
        rng_state = SEED;
        repeat (10) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;

        reset_state_test();
        output_drive_test();
        mixed_input_test();
        edge_irq_test();
        read_mux_test();

        wait_cycles(2);
        $display("Errors: %0d", error_count);
        if (error_count == 0)
            $display("Result: PASSED");
        else
            $display("Result: FAILED");
        $finish;
    end

endmodule

/* design/gpio_subsystem.sv */
/*
 * GPIO subsystem top level with the pin controller,
 * rising-edge interrupt unit and bus read multiplexer
 */

`timescale 1ns/100ps

module gpio_subsystem
    import io_bus_pkg::*;
#(
    parameter int NUM_PINS = 8,
    parameter logic [IO_DATA_WIDTH-1:0] GPIO_BASE = 32'h100,
    parameter logic [IO_DATA_WIDTH-1:0] IRQ_BASE = 32'h110,
    parameter bit ENABLE_SYNCHRONIZER = 1
)
(
    input  logic                     clk,
    input  logic                     reset,
    input  io_bus_req_t              bus_req,
    output logic [IO_DATA_WIDTH-1:0] read_data,
    output logic                     irq,
    inout  wire  [NUM_PINS-1:0]      gpio_pins
);

    // Sampled pins, shared by the controller read-back and the edge detector
    logic [NUM_PINS-1:0] pin_state;

    // Read data held by each peripheral since its last read hit
    logic [IO_DATA_WIDTH-1:0] gpio_read_data;
    logic [IO_DATA_WIDTH-1:0] irq_read_data;

    gpio_controller #(
        .BASE_ADDRESS(GPIO_BASE),
        .NUM_PINS(NUM_PINS),
        .ENABLE_SYNCHRONIZER(ENABLE_SYNCHRONIZER)
    ) gpio_controller_i (
        .clk(clk),
        .reset(reset),
        .bus_req(bus_req),
        .gpio_value(gpio_pins),
        .pin_state(pin_state),
        .read_data(gpio_read_data)
    );

    gpio_edge_irq #(
        .BASE_ADDRESS(IRQ_BASE),
        .NUM_PINS(NUM_PINS)
    ) gpio_edge_irq_i (
        .clk(clk),
        .reset(reset),
        .bus_req(bus_req),
        .pin_state(pin_state),
        .read_data(irq_read_data),
        .irq(irq)
    );

    // Picks the word of whichever peripheral the last read addressed
    io_read_mux #(
        .GPIO_BASE(GPIO_BASE),
        .IRQ_BASE(IRQ_BASE)
    ) io_read_mux_i (
        .clk(clk),
        .reset(reset),
        .bus_req(bus_req),
        .gpio_read_data(gpio_read_data),
        .irq_read_data(irq_read_data),
        .read_data(read_data)
    );

endmodule

/* design/io_read_mux.sv */
/*
 * Read multiplexer that records which peripheral a read
 * addressed and returns its data on the following cycle
 */

`timescale 1ns/100ps

module io_read_mux
    import io_bus_pkg::*;
#(
    parameter logic [IO_DATA_WIDTH-1:0] GPIO_BASE = 32'h100,
    parameter logic [IO_DATA_WIDTH-1:0] IRQ_BASE = 32'h110
)
(
    input  logic                     clk,
    input  logic                     reset,
    input  io_bus_req_t              bus_req,
    input  logic [IO_DATA_WIDTH-1:0] gpio_read_data,
    input  logic [IO_DATA_WIDTH-1:0] irq_read_data,
    output logic [IO_DATA_WIDTH-1:0] read_data
);

    // Source decoded from the current address
    periph_sel_t decoded_sel;

    // Source of the last read, held between reads
    periph_sel_t read_sel;

    // Only the mapped registers select a peripheral
    always_comb
    begin
        decoded_sel = SEL_NONE;
        if (bus_req.address == GPIO_BASE + OFFSET_DIRECTION
                || bus_req.address == GPIO_BASE + OFFSET_VALUE)
            decoded_sel = SEL_GPIO;
        else if (bus_req.address == IRQ_BASE + OFFSET_IRQ_MASK
                || bus_req.address == IRQ_BASE + OFFSET_IRQ_STATUS)
            decoded_sel = SEL_IRQ;
    end

    // Captured on the same edge as the peripherals capture their data
    always_ff @(posedge clk, posedge reset)
    begin
        if (reset)
            read_sel <= SEL_NONE;
        else if (bus_req.read_en)
            read_sel <= decoded_sel;
    end

    always_comb
    begin
        case (read_sel)
            SEL_GPIO: read_data = gpio_read_data;
            SEL_IRQ:  read_data = irq_read_data;
            default:  read_data = '0;
        endcase
    end

endmodule

/* design/gpio_edge_irq.sv */
/*
 * Rising-edge interrupt unit with a mask register,
 * a write-one-to-clear status register, registered
 * read-back and a level interrupt output
 */

`timescale 1ns/100ps

module gpio_edge_irq
    import io_bus_pkg::*;
#(
    parameter logic [IO_DATA_WIDTH-1:0] BASE_ADDRESS = 32'h0,
    parameter int NUM_PINS = 8
)
(
    input  logic                     clk,
    input  logic                     reset,
    input  io_bus_req_t              bus_req,
    input  logic [NUM_PINS-1:0]      pin_state,
    output logic [IO_DATA_WIDTH-1:0] read_data,
    output logic                     irq
);

    // Absolute addresses of the two registers
    localparam logic [IO_DATA_WIDTH-1:0] MASK_ADDR = BASE_ADDRESS + OFFSET_IRQ_MASK;
    localparam logic [IO_DATA_WIDTH-1:0] STATUS_ADDR = BASE_ADDRESS + OFFSET_IRQ_STATUS;

    // Pin state from the previous cycle
    logic [NUM_PINS-1:0] prev_state;

    // One bit per pin that has gone from 0 to 1 this cycle
    logic [NUM_PINS-1:0] rising;

    // Bits that a status write asks to clear
    logic [NUM_PINS-1:0] clear_bits;

    logic [NUM_PINS-1:0] mask;
    logic [NUM_PINS-1:0] status;

    // prev_state resets to zero, so a pin that is already high
    // counts as one edge when its first sample arrives
    assign rising = pin_state & ~prev_state;

    // Write-one-to-clear decode
    always_comb
    begin
        clear_bits = '0;
        if (bus_req.write_en && bus_req.address == STATUS_ADDR)
            clear_bits = bus_req.write_data[NUM_PINS-1:0];
    end

    always_ff @(posedge clk, posedge reset)
    begin
        if (reset)
        begin
            prev_state <= '0;
            mask <= '0;
            status <= '0;
        end
        else
        begin
            prev_state <= pin_state;

            // An edge in the same cycle as its clear keeps the bit set
            status <= (status & ~clear_bits) | rising;

            if (bus_req.write_en && bus_req.address == MASK_ADDR)
                mask <= bus_req.write_data[NUM_PINS-1:0];
        end
    end

    // Level interrupt, high while any enabled flag is pending
    assign irq = |(status & mask);

    // Read-back is captured on the read pulse and held until the next hit
    always_ff @(posedge clk)
    begin
        if (bus_req.read_en)
        begin
            if (bus_req.address == MASK_ADDR)
                read_data <= IO_DATA_WIDTH'(mask);
            else if (bus_req.address == STATUS_ADDR)
                read_data <= IO_DATA_WIDTH'(status);
        end
    end

endmodule

/* design/gpio_controller.sv */
/*
 * GPIO controller with direction and output registers,
 * tristate pin drivers, input sampling with an optional
 * synchronizer and registered read-back of its registers
 */

`timescale 1ns/100ps

module gpio_controller
    import io_bus_pkg::*;
#(
    parameter logic [IO_DATA_WIDTH-1:0] BASE_ADDRESS = 32'h0,
    parameter int NUM_PINS = 8,
    parameter bit ENABLE_SYNCHRONIZER = 1
)
(
    input  logic                     clk,
    input  logic                     reset,
    input  io_bus_req_t              bus_req,
    inout  wire  [NUM_PINS-1:0]      gpio_value,
    output logic [NUM_PINS-1:0]      pin_state,
    output logic [IO_DATA_WIDTH-1:0] read_data
);

    // Absolute addresses of the two registers
    localparam logic [IO_DATA_WIDTH-1:0] DIRECTION_ADDR = BASE_ADDRESS + OFFSET_DIRECTION;
    localparam logic [IO_DATA_WIDTH-1:0] VALUE_ADDR = BASE_ADDRESS + OFFSET_VALUE;

    // A set bit makes the pin an output
    logic [NUM_PINS-1:0] direction;

    // Value driven on the pins that are outputs
    logic [NUM_PINS-1:0] output_value;

    // Each pin drives its output bit only while it is configured as output
    // Input pins float and are driven from outside
    genvar pin_idx;
    generate
        for (pin_idx = 0; pin_idx < NUM_PINS; pin_idx++)
        begin : pin_driver_gen
            assign gpio_value[pin_idx] = direction[pin_idx]
                ? output_value[pin_idx] : 1'bz;
        end
    endgenerate

    // Pin sampling
    // With the synchronizer a pin change shows up on pin_state after two edges,
    // without it after one. Output pins read back their own driven value
    generate
        if (ENABLE_SYNCHRONIZER)
        begin : sync_gen
            synchronizer #(
                .WIDTH(NUM_PINS)
            ) input_synchronizer (
                .clk(clk),
                .reset(reset),
                .data_i(gpio_value),
                .data_o(pin_state)
            );
        end
        else
        begin : sample_gen
            always_ff @(posedge clk, posedge reset)
            begin
                if (reset)
                    pin_state <= '0;
                else
                    pin_state <= gpio_value;
            end
        end
    endgenerate

    // Register writes
    // The drivers follow the registers, so a write reaches the pins one edge later
    always_ff @(posedge clk, posedge reset)
    begin
        if (reset)
        begin
            direction <= '0;
            output_value <= '0;
        end
        else if (bus_req.write_en)
        begin
            if (bus_req.address == DIRECTION_ADDR)
                direction <= bus_req.write_data[NUM_PINS-1:0];
            else if (bus_req.address == VALUE_ADDR)
                output_value <= bus_req.write_data[NUM_PINS-1:0];
        end
    end

    // Read-back is captured on the read pulse and held until the next hit
    // The value register reads the sampled pins, not output_value
    always_ff @(posedge clk)
    begin
        if (bus_req.read_en)
        begin
            if (bus_req.address == DIRECTION_ADDR)
                read_data <= IO_DATA_WIDTH'(direction);
            else if (bus_req.address == VALUE_ADDR)
                read_data <= IO_DATA_WIDTH'(pin_state);
        end
    end

endmodule

/* design/synchronizer.sv */
/*
 * Two-flop synchronizer, one bit per lane,
 * asynchronous reset to zero
 */

`timescale 1ns/100ps

module synchronizer
#(
    parameter int WIDTH = 1
)
(
    input  logic             clk,
    input  logic             reset,
    input  logic [WIDTH-1:0] data_i,
    output logic [WIDTH-1:0] data_o
);

    // First stage may go metastable, it is only ever read by the second stage
    logic [WIDTH-1:0] meta;

    // Each lane is synchronized on its own
    // so lanes are not guaranteed to change in the same cycle
    always_ff @(posedge clk, posedge reset)
    begin
        if (reset)
        begin
            meta <= '0;
            data_o <= '0;
        end
        else
        begin
            meta <= data_i;
            data_o <= meta;
        end
    end

endmodule

/* design/io_bus_pkg.sv */
/*
 * Shared definitions for the peripheral I/O bus:
 * data width, bus request struct, register offsets
 * and the read source select enum
 */

package io_bus_pkg;

    // Width of the bus data words and of the address
    localparam int IO_DATA_WIDTH = 32;

    // One request on the strobe bus
    // write_en and read_en are single-cycle pulses and are never high together
    typedef struct packed {
        logic                     write_en;
        logic                     read_en;
        logic [IO_DATA_WIDTH-1:0] address;
        logic [IO_DATA_WIDTH-1:0] write_data;
    } io_bus_req_t;

    // Register offsets inside the GPIO controller window
    // A 1 in the direction register turns the pin into an output
    localparam logic [IO_DATA_WIDTH-1:0] OFFSET_DIRECTION = 32'h0;

    // Writes set the output values, reads return the sampled pin state
    localparam logic [IO_DATA_WIDTH-1:0] OFFSET_VALUE = 32'h4;

    // Register offsets inside the interrupt unit window
    // Per-pin enable for the interrupt line
    localparam logic [IO_DATA_WIDTH-1:0] OFFSET_IRQ_MASK = 32'h0;

    // Sticky rising-edge flags, cleared by writing 1 to a bit
    localparam logic [IO_DATA_WIDTH-1:0] OFFSET_IRQ_STATUS = 32'h4;

    // Source of the data that a pending read returns
    // SEL_NONE also covers addresses that hit no register
    typedef enum logic [1:0] {
        SEL_NONE = 2'd0,
        SEL_GPIO = 2'd1,
        SEL_IRQ  = 2'd2
    } periph_sel_t;

endpackage
